//--- sim/taylor_vectors.txt
// columns: test_id func_sel x tag expected_y, all hex, x and y in Q2.16
// a line with test id 0 ends the list
2 0 00000 1 00000
2 0 08000 2 07abb
2 0 38000 3 38544
2 0 10000 4 0d76b
2 0 30000 5 32895
3 1 00000 6 10000
3 1 08000 7 0e0a9
3 1 38000 8 0e0a9
3 1 10000 9 08a50
4 2 04000 a 0cccc
4 2 3c000 b 15555
4 2 00000 c 10000
4 3 10000 d 00000
4 7 38000 e 00000
// back to back, the last two meet a busy lane and are dropped
5 0 08000 0 07abb
5 1 10000 1 08a50
5 2 3c000 2 15555
5 1 00000 3 10000
5 0 10000 4 0d76b
5 2 04000 5 0cccc
6 1 38000 6 0e0a9
6 2 04000 7 0cccc
6 0 30000 8 32895
6 5 08000 9 00000
6 0 08000 a 07abb
0 0 00000 0 00000

//--- project.f
hw/taylor_pkg.sv
hw/taylor_coefs.sv
hw/taylor_dispatch.sv
hw/taylor_lane.sv
hw/taylor_collect.sv
hw/taylor_unit.sv
sim/taylor_checker.sv
sim/taylor_unit_tb.sv

//--- run_sim.sh
#!/bin/sh
verilator --binary --timing -Wno-fatal -f project.f --top-module taylor_unit_tb -o taylor_sim \
    && ./obj_dir/taylor_sim | tee /dev/stderr | grep -q "Test completed successfully" \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

//--- sim/taylor_unit_tb.sv
`timescale 1ns/1ps

module taylor_unit_tb;
    import taylor_pkg::*;

    localparam int max_vec        = 64;
    localparam int vec_cols       = 5;
    localparam int clk_period     = 40;
    localparam int cycles_per_vec = 20;

    logic                    clk;
    logic                    reset;
    logic                    req_valid;
    taylor_req_t             req;
    logic                    ready;
    logic                    resp_valid;
    taylor_resp_t            resp;
    // Expected values and test framing for the checker
    logic [7:0]              test_id;
    logic signed [fix_w-1:0] exp_y;
    logic                    test_end;
    int                      pending;
    int                      tests_done;
    int                      tests_failed;
    int                      total_errors;
    // Vector words, five per request
    logic [19:0]             vec_mem [0:max_vec*vec_cols-1];
    int                      num_vec;
    logic                    loaded;

    always #(clk_period / 2) clk = ~clk;

    taylor_unit taylor_unit_inst (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .ready      (ready),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

    taylor_checker checker_inst (
        .clk          (clk),
        .reset        (reset),
        .req_valid    (req_valid),
        .ready        (ready),
        .req          (req),
        .resp_valid   (resp_valid),
        .resp         (resp),
        .test_id      (test_id),
        .exp_y        (exp_y),
        .test_end     (test_end),
        .pending      (pending),
        .tests_done   (tests_done),
        .tests_failed (tests_failed),
        .total_errors (total_errors)
    );

    // Puts vector i on the bus, holds it until an accepting edge unless told not to wait
    task automatic present(input int i, input bit ignore_ready);
        req_valid    = 1'b1;
        req.func_sel = func_sel_t'(vec_mem[i*vec_cols+1][2:0]);
        req.x        = vec_mem[i*vec_cols+2][fix_w-1:0];
        req.tag      = vec_mem[i*vec_cols+3][tag_w-1:0];
        exp_y        = vec_mem[i*vec_cols+4][fix_w-1:0];
        while (!ignore_ready && !ready) begin
            @(posedge clk);
            #2;
        end
        @(posedge clk);
        #2;
    endtask

    // Idle until all accepted requests are back, then close the test
    task automatic finish_test();
        req_valid = 1'b0;
        wait (pending == 0);
        @(posedge clk);
        #2;
        test_end = 1'b1;
        @(posedge clk);
        #2;
        test_end = 1'b0;
    endtask

    // ------------------------------------------------------------
    // Stimulus
    // ------------------------------------------------------------
    initial begin
        int i;
        int gap;
        clk       = 1'b0;
        reset     = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        test_id   = 8'd1;
        exp_y     = '0;
        test_end  = 1'b0;
        loaded    = 1'b0;
        num_vec   = 0;
        void'($urandom(64));
        $readmemh("sim/taylor_vectors.txt", vec_mem);
        // Vector list ends at a zero test id
        while (num_vec < max_vec && vec_mem[num_vec*vec_cols] != 0)
            num_vec++;
        loaded = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        // Reset state, bus left idle
        repeat (4) @(posedge clk);
        #2;
        finish_test();
        for (i = 0; i < num_vec; i++) begin
            if (i > 0 && vec_mem[i*vec_cols] != vec_mem[(i-1)*vec_cols])
                finish_test();
            test_id = vec_mem[i*vec_cols][7:0];
            // Test 5 drives every cycle regardless of ready
            present(i, test_id == 8'd5);
            if (test_id == 8'd6) begin
                req_valid = 1'b0;
                gap = $urandom_range(3, 0);
                repeat (gap) begin
                    @(posedge clk);
                    #2;
                end
            end
        end
        finish_test();
        $display("%0d tests run, %0d failed, %0d errors, %0d vectors read",
                 tests_done, tests_failed, total_errors, num_vec);
        if (num_vec > 0 && tests_failed == 0 && total_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            if (num_vec == 0)
                $display("no vectors were read from sim/taylor_vectors.txt");
            $display("Test failed");
        end
        $finish;
    end

    // Watchdog, scaled by the vector count
    initial begin
        wait (loaded);
        #(num_vec * cycles_per_vec * clk_period + 2000);
        $display("watchdog: run still going after %0d ns, results stopped arriving",
                 num_vec * cycles_per_vec * clk_period + 2000);
        $display("Test failed");
        $finish;
    end

endmodule

//--- sim/taylor_checker.sv
`timescale 1ns/1ps

module taylor_checker (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 req_valid,
    input  logic                                 ready,
    input  taylor_pkg::taylor_req_t              req,
    input  logic                                 resp_valid,
    input  taylor_pkg::taylor_resp_t             resp,
    input  logic [7:0]                           test_id,
    input  logic signed [taylor_pkg::fix_w-1:0]  exp_y,
    input  logic                                 test_end,
    output int                                   pending,
    output int                                   tests_done,
    output int                                   tests_failed,
    output int                                   total_errors
);
    import taylor_pkg::*;

    // Accepting edge to the edge that sees resp_valid
    localparam int latency = 13;

    typedef struct packed {
        logic [7:0]   id;
        taylor_resp_t resp;
        logic [31:0]  cycle;
    } expect_t;

    expect_t     exp_q [$];
    expect_t     entry;
    expect_t     head;
    logic [31:0] cycle;
    // Cycle at which each lane turns idle again
    int          lane_free [num_lanes];
    int          rr_ptr;
    logic        exp_ready;
    int          checks;
    int          errors;

    function automatic string test_name(input logic [7:0] id);
        case (id)
            8'd1:    return "reset_state";
            8'd2:    return "sin";
            8'd3:    return "cos";
            8'd4:    return "inv_and_unsupported";
            8'd5:    return "back_to_back";
            8'd6:    return "random_gaps";
            default: return "unknown";
        endcase
    endfunction

    // ------------------------------------------------------------
    // Sampled on the falling edge away from DUT updates
    // ------------------------------------------------------------
    always @(negedge clk) begin
        if (reset) begin
            cycle        = 0;
            rr_ptr       = 0;
            checks       = 0;
            errors       = 0;
            tests_done   = 0;
            tests_failed = 0;
            total_errors = 0;
            foreach (lane_free[k])
                lane_free[k] = 0;
            exp_q.delete();
        end else begin
            cycle = cycle + 1;
            // Ready only once the pointed lane has drained
            exp_ready = (cycle >= lane_free[rr_ptr]);
            checks++;
            if (ready !== exp_ready) begin
                $display("mismatch %s: expected ready=%b, actual ready=%b",
                         test_name(test_id), exp_ready, ready);
                errors++;
            end
            // Expected result travels with each accepted request
            if (req_valid && exp_ready) begin
                entry.id       = test_id;
                entry.resp.y   = exp_y;
                entry.resp.tag = req.tag;
                entry.cycle    = cycle;
                exp_q.push_back(entry);
                // Lane frees up as its result leaves the collector
                lane_free[rr_ptr] = cycle + latency;
                rr_ptr = (rr_ptr + 1) % num_lanes;
            end
            if (resp_valid) begin
                checks++;
                if (exp_q.size() == 0) begin
                    $display("test %s: result with tag %h arrived with no request pending",
                             test_name(test_id), resp.tag);
                    errors++;
                end else begin
                    head = exp_q.pop_front();
                    if (resp !== head.resp) begin
                        $display("mismatch %s: expected y=%05h tag=%h, actual y=%05h tag=%h",
                                 test_name(head.id), head.resp.y, head.resp.tag,
                                 resp.y, resp.tag);
                        errors++;
                    end
                    if (cycle - head.cycle != latency) begin
                        $display("test %s: tag %h came %0d cycles after acceptance, not %0d",
                                 test_name(head.id), head.resp.tag, cycle - head.cycle,
                                 latency);
                        errors++;
                    end
                end
            end
            // One line per finished test
            if (test_end) begin
                $display("test %s: %0d checks, %0d errors, %s", test_name(test_id),
                         checks, errors, (errors == 0) ? "pass" : "FAIL");
                tests_done++;
                if (errors != 0)
                    tests_failed++;
                total_errors += errors;
                checks = 0;
                errors = 0;
            end
            pending = exp_q.size();
        end
    end

endmodule

//--- hw/taylor_unit.sv
`timescale 1ns/1ps

module taylor_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       req_valid,
    input  taylor_pkg::taylor_req_t    req,
    output logic                       ready,
    output logic                       resp_valid,
    output taylor_pkg::taylor_resp_t   resp
);
    import taylor_pkg::*;

    // Dispatcher to lanes
    logic [num_lanes-1:0] lane_start;
    logic [num_lanes-1:0] lane_busy;
    taylor_req_t          lane_req;
    // Lanes to collector
    logic [num_lanes-1:0] lane_done;
    taylor_resp_t         lane_resp [num_lanes];

    taylor_dispatch dispatch_inst (
        .clk        (clk),
        .reset      (reset),
        .req_valid  (req_valid),
        .req        (req),
        .lane_busy  (lane_busy),
        .ready      (ready),
        .lane_start (lane_start),
        .lane_req   (lane_req)
    );

    // ------------------------------------------------------------
    // Evaluation lanes
    // ------------------------------------------------------------
    for (genvar i = 0; i < num_lanes; i++) begin : g_lane
        taylor_lane lane_inst (
            .clk   (clk),
            .reset (reset),
            .start (lane_start[i]),
            .req   (lane_req),
            .busy  (lane_busy[i]),
            .done  (lane_done[i]),
            .resp  (lane_resp[i])
        );
    end

    taylor_collect collect_inst (
        .clk        (clk),
        .reset      (reset),
        .lane_done  (lane_done),
        .lane_resp  (lane_resp),
        .resp_valid (resp_valid),
        .resp       (resp)
    );

endmodule

//--- hw/taylor_collect.sv
`timescale 1ns/1ps

module taylor_collect (
    input  logic                               clk,
    input  logic                               reset,
    input  logic [taylor_pkg::num_lanes-1:0]   lane_done,
    input  taylor_pkg::taylor_resp_t           lane_resp [taylor_pkg::num_lanes],
    output logic                               resp_valid,
    output taylor_pkg::taylor_resp_t           resp
);
    import taylor_pkg::*;

    taylor_resp_t sel_resp;

    // ------------------------------------------------------------
    // Lane select
    // ------------------------------------------------------------
    // Fixed latency keeps done one-hot, so a plain scan is enough
    always_comb begin
        sel_resp = lane_resp[0];
        for (int i = 0; i < num_lanes; i++) begin
            if (lane_done[i])
                sel_resp = lane_resp[i];
        end
    end

    // Output strobe
    always_ff @(posedge clk) begin
        if (reset)
            resp_valid <= 1'b0;
        else
            resp_valid <= |lane_done;
    end

    // Result register, holds between completions
    always_ff @(posedge clk) begin
        if (|lane_done)
            resp <= sel_resp;
    end

endmodule

//--- hw/taylor_lane.sv
`timescale 1ns/1ps

module taylor_lane (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  taylor_pkg::taylor_req_t    req,
    output logic                       busy,
    output logic                       done,
    output taylor_pkg::taylor_resp_t   resp
);
    import taylor_pkg::*;

    // Control state
    logic                      active_q;
    logic [idx_w-1:0]          idx_q;
    logic [idx_w-1:0]          idx_next;
    // Latched request fields
    func_sel_t                 func_q;
    logic signed [fix_w-1:0]   x_q;
    logic [tag_w-1:0]          tag_q;
    // Datapath
    logic signed [fix_w-1:0]   acc_q;
    logic signed [fix_w-1:0]   coef;
    logic signed [2*fix_w-1:0] prod;
    logic signed [fix_w-1:0]   acc_next;
    func_sel_t                 coef_func;
    logic [idx_w-1:0]          coef_idx;

    assign idx_next = idx_q - 1'b1;

    // Table looks at the incoming request during start
    assign coef_func = start ? req.func_sel : func_q;
    assign coef_idx  = start ? idx_w'(max_idx) : idx_next;

    taylor_coefs coefs_inst (
        .func_sel (coef_func),
        .idx      (coef_idx),
        .coef     (coef)
    );

    // ------------------------------------------------------------
    // Horner step: acc*x, truncate by 16, add coefficient, wrap
    // ------------------------------------------------------------
    assign prod     = acc_q * x_q;
    assign acc_next = fix_w'(prod >>> frac_w) + coef;

    // ------------------------------------------------------------
    // Sequencer
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            active_q <= 1'b0;
            done     <= 1'b0;
            idx_q    <= '0;
        end else if (start) begin
            active_q <= 1'b1;
            done     <= 1'b0;
            idx_q    <= idx_w'(max_idx);
        end else if (done) begin
            // Done cycle over, lane free again
            active_q <= 1'b0;
            done     <= 1'b0;
        end else if (active_q) begin
            idx_q <= idx_next;
            done  <= (idx_next == '0);
        end
    end

    // Payload registers
    always_ff @(posedge clk) begin
        if (start) begin
            func_q <= req.func_sel;
            x_q    <= req.x;
            tag_q  <= req.tag;
            acc_q  <= coef;
        end else if (active_q && !done) begin
            acc_q <= acc_next;
        end
    end

    // Busy covers the start cycle through the done cycle
    assign busy = start || active_q;

    // Result held in the accumulator during done
    assign resp.y   = acc_q;
    assign resp.tag = tag_q;

endmodule

//--- hw/taylor_dispatch.sv
`timescale 1ns/1ps

module taylor_dispatch (
    input  logic                               clk,
    input  logic                               reset,
    input  logic                               req_valid,
    input  taylor_pkg::taylor_req_t            req,
    input  logic [taylor_pkg::num_lanes-1:0]   lane_busy,
    output logic                               ready,
    output logic [taylor_pkg::num_lanes-1:0]   lane_start,
    output taylor_pkg::taylor_req_t            lane_req
);
    import taylor_pkg::*;

    // Round-robin pointer, next lane to receive a request
    logic [lane_idx_w-1:0] ptr_q;
    logic                  accept;

    // Ready only follows the pointed lane, no lookahead
    assign ready  = !lane_busy[ptr_q];
    assign accept = req_valid && ready;

    // ------------------------------------------------------------
    // Pointer and start strobes
    // ------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (reset) begin
            ptr_q      <= '0;
            lane_start <= '0;
        end else begin
            // Strobes last one cycle
            lane_start <= '0;
            if (accept) begin
                lane_start[ptr_q] <= 1'b1;
                if (ptr_q == lane_idx_w'(num_lanes - 1))
                    ptr_q <= '0;
                else
                    ptr_q <= ptr_q + 1'b1;
            end
        end
    end

    // Shared request register, valid alongside the start strobe
    always_ff @(posedge clk) begin
        if (accept)
            lane_req <= req;
    end

endmodule

//--- hw/taylor_coefs.sv
`timescale 1ns/1ps

module taylor_coefs (
    input  taylor_pkg::func_sel_t                 func_sel,
    input  logic [taylor_pkg::idx_w-1:0]          idx,
    output logic signed [taylor_pkg::fix_w-1:0]   coef
);
    import taylor_pkg::*;

    // Derivative values at zero, per function
    logic signed [fix_w-1:0]   sign_sin;
    logic signed [fix_w-1:0]   sign_cos;
    logic signed [fix_w-1:0]   sign_inv;
    // 1/n! in Q2.16, truncated
    logic signed [fix_w-1:0]   inv_fact;
    // Sign times 1/n!, full width then rescaled
    logic signed [2*fix_w-1:0] prod_sin;
    logic signed [2*fix_w-1:0] prod_cos;

    // ------------------------------------------------------------
    // Derivative sign tables
    // ------------------------------------------------------------
    // sin: 0, +1, 0, -1 repeating
    always_comb begin
        case (idx)
            4'h1, 4'h5, 4'h9: sign_sin = fix_one;
            4'h3, 4'h7:       sign_sin = fix_neg_one;
            default:          sign_sin = '0;
        endcase
    end

    // cos: +1, 0, -1, 0 repeating
    always_comb begin
        case (idx)
            4'h0, 4'h4, 4'h8: sign_cos = fix_one;
            4'h2, 4'h6, 4'ha: sign_cos = fix_neg_one;
            default:          sign_cos = '0;
        endcase
    end

    // 1/(1+x): alternating, already the series coefficient
    always_comb begin
        if (idx > idx_w'(max_idx)) sign_inv = '0;
        else if (idx[0])           sign_inv = fix_neg_one;
        else                       sign_inv = fix_one;
    end

    // ------------------------------------------------------------
    // Inverse factorial table
    // ------------------------------------------------------------
    always_comb begin
        case (idx)
            4'h0, 4'h1: inv_fact = 18'sh10000;
            4'h2:       inv_fact = 18'sh08000;
            4'h3:       inv_fact = 18'sh02aaa;
            4'h4:       inv_fact = 18'sh00aaa;
            4'h5:       inv_fact = 18'sh00222;
            4'h6:       inv_fact = 18'sh0005b;
            4'h7:       inv_fact = 18'sh0000d;
            4'h8:       inv_fact = 18'sh00001;
            // 1/9! and 1/10! fall below one LSB
            default:    inv_fact = '0;
        endcase
    end

    // Q2.16 products, exact since the sign is 0 or +-1.0
    assign prod_sin = sign_sin * inv_fact;
    assign prod_cos = sign_cos * inv_fact;

    // Function select, unknown codes give zero
    always_comb begin
        case (func_sel)
            func_sin:          coef = fix_w'(prod_sin >>> frac_w);
            func_cos:          coef = fix_w'(prod_cos >>> frac_w);
            func_inv_1_plus_x: coef = sign_inv;
            default:           coef = '0;
        endcase
    end

endmodule

//--- hw/taylor_pkg.sv
package taylor_pkg;

    // ------------------------------------------------------------
    // Fixed-point format, Q2.16 signed
    // ------------------------------------------------------------
    localparam int fix_w  = 18;
    localparam int frac_w = 16;

    // Series length, indices 0 up to max_idx
    localparam int num_terms = 11;
    localparam int idx_w     = 4;
    localparam int max_idx   = num_terms - 1;

    // Lane array and round-robin pointer
    localparam int num_lanes  = 4;
    localparam int lane_idx_w = $clog2(num_lanes);

    // Request tag, returned untouched with the result
    localparam int tag_w = 4;

    // Unit values in Q2.16, used as derivative signs
    localparam logic signed [fix_w-1:0] fix_one     = 18'sh10000;
    localparam logic signed [fix_w-1:0] fix_neg_one = -fix_one;

    // ------------------------------------------------------------
    // Function codes
    // ------------------------------------------------------------
    // Codes 3 to 7 are legal on the bus and evaluate to zero
    typedef enum logic [2:0] {
        func_sin          = 3'd0,
        func_cos          = 3'd1,
        func_inv_1_plus_x = 3'd2
    } func_sel_t;

    // ------------------------------------------------------------
    // Request and response payloads
    // ------------------------------------------------------------
    typedef struct packed {
        func_sel_t                 func_sel;
        logic signed [fix_w-1:0]   x;
        logic        [tag_w-1:0]   tag;
    } taylor_req_t;

    typedef struct packed {
        logic signed [fix_w-1:0]   y;
        logic        [tag_w-1:0]   tag;
    } taylor_resp_t;

endpackage
